// File: common/stream_pkg.sv
/* stream word and beat types shared by both sides of the FIFO
   the word width is fixed here and cannot be set per instance */
package stream_pkg;

    // width of one payload word in bits
    localparam int STREAM_WORD_WIDTH = 8;

    // one payload word as it is stored in the buffer RAM
    typedef logic [STREAM_WORD_WIDTH-1:0] stream_word_t;

    // one beat of a ready/valid stream; ready travels on its own wire
    // in the opposite direction, so it is not part of the beat
    typedef struct packed {
        logic         valid;
        stream_word_t data;
    } stream_beat_t;

    // how much the FIFO holds, counting the word in the output register
    // busy covers every count from 1 to DEPTH-1
    typedef enum logic [1:0] {
        FILL_EMPTY = 2'b00,
        FILL_BUSY  = 2'b01,
        FILL_FULL  = 2'b10
    } fill_state_e;

endpackage

// File: common/buffer_pkg.sv
/* control word from the FIFO control block to its storage
   all fields are single-cycle strobes, valid in the cycle they are high */
package buffer_pkg;

    // write_enable also advances the write address counter, since every
    // write fills exactly one new slot
    // read_enable loads the RAM output register from the read address
    // advance_read steps the read address counter on to the next slot
    // update_output lets the output valid register take a new value
    typedef struct packed {
        logic write_enable;
        logic read_enable;
        logic advance_read;
        logic update_output;
    } buffer_ctrl_t;

endpackage

// File: pipeline_fifo/wrap_address_counter.sv
/* counts 0 to DEPTH-1 and wraps, so DEPTH need not be a power of two
   advances at most one step per cycle */
`timescale 1ns/1ns

module wrap_address_counter #(
    parameter int DEPTH = 4
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     advance,
    output logic [$clog2(DEPTH)-1:0] addr
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);
    // last valid slot, after which the address goes back to zero
    localparam logic [ADDR_WIDTH-1:0] ADDR_LAST = ADDR_WIDTH'(DEPTH - 1);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (clear) begin
            addr <= '0;
        end else if (advance) begin
            // wrap explicitly, the natural binary rollover only fits powers of two
            if (addr == ADDR_LAST) begin
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    // with a non power of two depth the upper codes must never show up
    a_addr_in_range : assert property (
        @(posedge clock) disable iff (!rst_n)
        int'(addr) < DEPTH
    ) else $error("address counter left the 0 to DEPTH-1 range");

endmodule

// File: pipeline_fifo/simple_dual_port_ram.sv
/* one write port, one registered read port, storage has no reset
   no write forwarding, so a read and a write must never hit the same address */
`timescale 1ns/1ns

module simple_dual_port_ram #(
    parameter int DEPTH = 4
) (
    input  logic                     clock,
    input  buffer_pkg::buffer_ctrl_t buffer_ctrl,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    input  stream_pkg::stream_word_t write_data,
    output stream_pkg::stream_word_t read_data
);
    import stream_pkg::*;

    stream_word_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (buffer_ctrl.write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // the read register holds its word until the next read, which keeps the
    // FIFO output stable during back-pressure
    always_ff @(posedge clock) begin
        if (buffer_ctrl.read_enable) begin
            read_data <= mem[read_addr];
        end
    end

    // the control block keeps the two counters apart whenever both ports work,
    // which is what lets this RAM skip collision handling
    a_no_address_collision : assert property (
        @(posedge clock)
        buffer_ctrl.write_enable && buffer_ctrl.read_enable |-> write_addr != read_addr
    ) else $error("RAM read and write to the same address in one cycle");

endmodule

// File: pipeline_fifo/fifo_flow_control.sv
/* occupancy counts every word accepted and not yet delivered, output register included
   clear and rst_n both return it to empty; clear wins over a handshake in the same cycle */
`timescale 1ns/1ns

module fifo_flow_control #(
    parameter int DEPTH = 4
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     in_valid,
    output logic                     in_ready,
    output logic                     out_valid,
    input  logic                     out_ready,
    output buffer_pkg::buffer_ctrl_t buffer_ctrl,
    output stream_pkg::fill_state_e  fill_state
);
    import stream_pkg::*;

    // the count must reach DEPTH itself, so it needs room for DEPTH+1 values
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
    localparam logic [COUNT_WIDTH-1:0] COUNT_ZERO = '0;
    localparam logic [COUNT_WIDTH-1:0] COUNT_FULL = COUNT_WIDTH'(DEPTH);

    // the held word count is the whole FSM state
    logic [COUNT_WIDTH-1:0] word_count;
    // words still sitting in the RAM that have not been read out yet
    logic [COUNT_WIDTH-1:0] unread_count;

    logic empty;
    logic busy;
    logic full;
    logic insert;
    logic remove;
    logic load;
    logic unload;
    logic flow;

    assign empty = (word_count == COUNT_ZERO);
    assign full  = (word_count == COUNT_FULL);
    assign busy  = !empty && !full;

    // input side only stops the sender when every slot is taken
    assign in_ready = !full;
    assign insert   = in_valid && in_ready;

    // a word leaves the FIFO only on an output handshake
    assign remove = out_valid && out_ready;

    // the word in the output register has already left the RAM
    assign unread_count = word_count - COUNT_WIDTH'(out_valid);

    // load counts up, unload counts down, flow keeps the count
    // flow can only happen in the busy range, since insert needs a free slot
    // and remove needs a held word
    assign load   = insert && !remove;
    assign unload = remove && !insert;
    assign flow   = busy && insert && remove;

    always_comb begin
        // the output register may change when it is empty or being emptied
        buffer_ctrl.update_output = !out_valid || out_ready;
        // prefetch from the RAM whenever the output register can take a word
        buffer_ctrl.read_enable   = buffer_ctrl.update_output && (unread_count != COUNT_ZERO);
        // every read takes one slot out of the RAM, prefetch or not
        buffer_ctrl.advance_read  = buffer_ctrl.read_enable;
        // every accepted word goes straight into the RAM
        buffer_ctrl.write_enable  = load || flow;
    end

    always_comb begin
        if (full) begin
            fill_state = FILL_FULL;
        end else if (busy) begin
            fill_state = FILL_BUSY;
        end else begin
            fill_state = FILL_EMPTY;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            word_count <= COUNT_ZERO;
        end else if (clear) begin
            word_count <= COUNT_ZERO;
        end else if (load) begin
            word_count <= word_count + 1'b1;
        end else if (unload) begin
            word_count <= word_count - 1'b1;
        end
    end

    // valid follows the read strobe one cycle later, matching the RAM latency
    // while the consumer stalls a full output register, nothing here moves
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (clear) begin
            out_valid <= 1'b0;
        end else if (buffer_ctrl.update_output) begin
            out_valid <= buffer_ctrl.read_enable;
        end
    end

    // out_valid never runs ahead of the count, so an empty FIFO never reads
    a_no_read_when_empty : assert property (
        @(posedge clock) disable iff (!rst_n)
        empty |-> !buffer_ctrl.read_enable && !out_valid
    ) else $error("RAM read or output valid while the FIFO is empty");

    a_count_in_range : assert property (
        @(posedge clock) disable iff (!rst_n)
        word_count <= COUNT_FULL
    ) else $error("held word count above DEPTH");

endmodule

// File: pipeline_fifo/pipeline_fifo_buffer.sv
/* ready/valid FIFO with two cycles from input valid to output valid and no
   combinational path from input to output; DEPTH may be any value from 2 up */
`timescale 1ns/1ns

module pipeline_fifo_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     clear,
    input  stream_pkg::stream_beat_t in_beat,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready,
    output stream_pkg::fill_state_e  fill_state
);
    import stream_pkg::*;
    import buffer_pkg::*;

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    buffer_ctrl_t          buffer_ctrl;
    logic [ADDR_WIDTH-1:0] write_addr;
    logic [ADDR_WIDTH-1:0] read_addr;
    logic                  out_valid;
    stream_word_t          read_data;

    // the RAM read register is the output data register, so valid and data
    // both come straight from flops
    assign out_beat = '{valid: out_valid, data: read_data};

    fifo_flow_control #(
        .DEPTH       (DEPTH)
    ) flow_control (
        .clock       (clock),
        .rst_n       (rst_n),
        .clear       (clear),
        .in_valid    (in_beat.valid),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .buffer_ctrl (buffer_ctrl),
        .fill_state  (fill_state)
    );

    // write side steps once per accepted word
    wrap_address_counter #(
        .DEPTH   (DEPTH)
    ) write_counter (
        .clock   (clock),
        .rst_n   (rst_n),
        .clear   (clear),
        .advance (buffer_ctrl.write_enable),
        .addr    (write_addr)
    );

    // read side steps once per word moved into the output register
    wrap_address_counter #(
        .DEPTH   (DEPTH)
    ) read_counter (
        .clock   (clock),
        .rst_n   (rst_n),
        .clear   (clear),
        .advance (buffer_ctrl.advance_read),
        .addr    (read_addr)
    );

    simple_dual_port_ram #(
        .DEPTH       (DEPTH)
    ) buffer_ram (
        .clock       (clock),
        .buffer_ctrl (buffer_ctrl),
        .write_addr  (write_addr),
        .read_addr   (read_addr),
        .write_data  (in_beat.data),
        .read_data   (read_data)
    );

endmodule

// File: bench/fifo_reference_checks.sv
/* reference queue model of the FIFO and the assertions that compare the DUT with it
   words move in the model on the DUT's own handshakes; check_failed stays high after a miss */
`timescale 1ns/1ns

module fifo_reference_checks #(
    parameter int DEPTH = 5
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     clear,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_ready,
    input  stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready,
    input  stream_pkg::fill_state_e  fill_state,
    output logic                     check_failed
);
    import stream_pkg::*;

    // accepted words that have not been delivered yet, oldest first
    stream_word_t model_queue[$];
    int           model_count;
    stream_word_t model_head;
    logic         accept;
    logic         deliver;
    // both handshake lines were high in the previous cycle and nothing cleared
    logic         was_streaming;
    // high in the first cycle after a clear or a reset
    logic         just_cleared;
    stream_beat_t last_out_beat;

    assign accept  = in_beat.valid && in_ready;
    assign deliver = out_beat.valid && out_ready;

    initial check_failed = 1'b0;

    // the fill level follows only from how many words are held
    function automatic fill_state_e expected_fill(input int count);
        if (count == 0) begin
            return FILL_EMPTY;
        end
        return (count == DEPTH) ? FILL_FULL : FILL_BUSY;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name,
                 expected, actual);
        check_failed = 1'b1;
    endtask

    task automatic report_problem(input string what);
        $display("check failed at %0t ns: %s", $time, what);
        check_failed = 1'b1;
    endtask

    // delivery comes out of the queue before the new word goes in, so a word
    // accepted and a word delivered on the same edge keep their order
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n || clear) begin
            model_queue.delete();
        end else begin
            if (deliver && model_queue.size() > 0) begin
                void'(model_queue.pop_front());
            end
            if (accept) begin
                model_queue.push_back(in_beat.data);
            end
        end
        model_count <= model_queue.size();
        model_head  <= (model_queue.size() > 0) ? model_queue[0] : '0;
    end

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            was_streaming <= 1'b0;
            just_cleared  <= 1'b1;
            last_out_beat <= '0;
        end else begin
            was_streaming <= in_beat.valid && out_ready && !clear;
            just_cleared  <= clear;
            last_out_beat <= out_beat;
        end
    end

    // in_ready and fill_state after a clear are covered by the two checks further down
    a_valid_low_after_clear : assert property (@(posedge clock) disable iff (!rst_n)
        just_cleared |-> !out_beat.valid
    ) else report_mismatch("out_beat.valid", 0, $sampled(out_beat.valid));

    a_deliver_needs_word : assert property (@(posedge clock) disable iff (!rst_n)
        deliver |-> model_count > 0
    ) else report_problem("output handshake while the reference queue is empty");

    a_deliver_in_order : assert property (@(posedge clock) disable iff (!rst_n)
        deliver && model_count > 0 |-> out_beat.data == model_head
    ) else report_mismatch("out_beat.data", $sampled(model_head), $sampled(out_beat.data));

    // a stalled consumer must see the same beat again on the next edge
    a_hold_under_backpressure : assert property (@(posedge clock) disable iff (!rst_n)
        out_beat.valid && !out_ready && !clear |=> out_beat == last_out_beat
    ) else report_mismatch("out_beat", $sampled(last_out_beat), $sampled(out_beat));

    a_count_bounded : assert property (@(posedge clock) disable iff (!rst_n)
        model_count <= DEPTH
    ) else report_problem("more than DEPTH words accepted and not delivered");

    a_ready_matches_count : assert property (@(posedge clock) disable iff (!rst_n)
        in_ready == (model_count != DEPTH)
    ) else report_mismatch("in_ready", $sampled(model_count != DEPTH), $sampled(in_ready));

    a_fill_state_matches : assert property (@(posedge clock) disable iff (!rst_n)
        fill_state == expected_fill(model_count)
    ) else report_mismatch("fill_state", expected_fill($sampled(model_count)),
                           $sampled(fill_state));

    // two streaming cycles in a row guarantee a word ready behind the output
    a_no_bubbles : assert property (@(posedge clock) disable iff (!rst_n)
        was_streaming && in_beat.valid && out_ready && !clear && out_beat.valid
        |=> out_beat.valid
    ) else report_mismatch("out_beat.valid", 1, $sampled(out_beat.valid));

    // valid stays low in the cycle after the accepting edge
    a_no_early_valid : assert property (@(posedge clock) disable iff (!rst_n)
        accept && model_count == 0 && !clear |=> !out_beat.valid
    ) else report_mismatch("out_beat.valid", 0, $sampled(out_beat.valid));

    // and rises after the next edge, unless a clear comes in between
    a_two_cycle_latency : assert property (@(posedge clock) disable iff (!rst_n)
        accept && model_count == 0 && !clear ##1 !clear
        |=> out_beat.valid
    ) else report_mismatch("out_beat.valid", 1, $sampled(out_beat.valid));

endmodule

// File: bench/pipeline_fifo_tb.sv
/* runs the FIFO with DEPTH 5 through seeded random traffic phases
   the reference checker does all comparing; this module stops the run on its first flag */
`timescale 1ns/1ns

module pipeline_fifo_tb;
    import stream_pkg::*;

    localparam int DEPTH = 5;
    // cycles allowed for the FIFO to fill up or drain before a wait gives up
    localparam int WAIT_LIMIT = 50;

    logic         clock;
    logic         rst_n;
    logic         clear;
    stream_beat_t in_beat;
    logic         in_ready;
    stream_beat_t out_beat;
    logic         out_ready;
    fill_state_e  fill_state;
    logic         check_failed;

    pipeline_fifo_buffer #(.DEPTH(DEPTH)) i_pipeline_fifo_buffer (
        .clock      (clock),
        .rst_n      (rst_n),
        .clear      (clear),
        .in_beat    (in_beat),
        .in_ready   (in_ready),
        .out_beat   (out_beat),
        .out_ready  (out_ready),
        .fill_state (fill_state)
    );

    fifo_reference_checks #(.DEPTH(DEPTH)) reference_checks (
        .clock        (clock),
        .rst_n        (rst_n),
        .clear        (clear),
        .in_beat      (in_beat),
        .in_ready     (in_ready),
        .out_beat     (out_beat),
        .out_ready    (out_ready),
        .fill_state   (fill_state),
        .check_failed (check_failed)
    );

    // 40 ns period
    always #20 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    // every input change happens on a falling edge, away from the sampling edge
    task automatic next_cycle();
        @(negedge clock);
        if (check_failed) begin
            abort_run("a reference check failed, see the line above");
        end
    endtask

    // the three numbers are chances in percent that the line is driven high
    task automatic random_cycle(input int valid_pct, input int ready_pct, input int clear_pct);
        next_cycle();
        in_beat.valid = ($urandom % 100) < valid_pct;
        in_beat.data  = stream_word_t'($urandom);
        out_ready     = ($urandom % 100) < ready_pct;
        clear         = ($urandom % 100) < clear_pct;
    endtask

    task automatic wait_until_full();
        int cycles = 0;
        while (in_ready) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run("timeout while waiting for the FIFO to fill up");
            end
            random_cycle(100, 0, 0);
            cycles++;
        end
    endtask

    task automatic wait_until_empty();
        int cycles = 0;
        while (fill_state != FILL_EMPTY) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run("timeout while waiting for the FIFO to drain");
            end
            random_cycle(0, 100, 0);
            cycles++;
        end
    endtask

    initial begin
        void'($urandom(32'hadda));
        clock     = 1'b0;
        rst_n     = 1'b0;
        clear     = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clock);
        next_cycle();
        rst_n = 1'b1;
        // free flow in both directions
        repeat (200) random_cycle(70, 70, 0);
        // consumer stalled, so the FIFO fills and the output beat must hold
        wait_until_full();
        repeat (10) random_cycle(60, 0, 0);
        // producer idle while the FIFO drains, then fill again and clear it while full
        wait_until_empty();
        wait_until_full();
        random_cycle(0, 0, 100);
        // sparse words, most of them land in an empty FIFO
        repeat (60) random_cycle(15, 80, 0);
        // both sides held high from empty, one word per cycle once valid rises
        wait_until_empty();
        repeat (40) random_cycle(100, 100, 0);
        // clear pulses mixed into random traffic
        repeat (300) random_cycle(60, 50, 8);
        repeat (4) random_cycle(0, 100, 0);
        if (check_failed) begin
            abort_run("a reference check failed near the end of the run");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: sources.f
common/stream_pkg.sv
common/buffer_pkg.sv
pipeline_fifo/wrap_address_counter.sv
pipeline_fifo/simple_dual_port_ram.sv
pipeline_fifo/fifo_flow_control.sv
pipeline_fifo/pipeline_fifo_buffer.sv
bench/fifo_reference_checks.sv
bench/pipeline_fifo_tb.sv
